// File: include/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// --------------------------------------------------
// Data path sizing
// --------------------------------------------------

// Width of operands and results
`define XLEN 32

// Width of a register file address
`define REG_AW 5

`endif

// File: logic/exec_pkg.sv
package exec_pkg;

  // --------------------------------------------------
  // Unit selection
  // --------------------------------------------------

  typedef enum logic [0:0] {
    UNIT_ALU = 1'b0,
    UNIT_DIV = 1'b1
  } unit_e;

  // --------------------------------------------------
  // Operation codes
  // --------------------------------------------------

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    LUI  = 4'd10  // Immediate goes straight to the result
  } alu_op_e;

  typedef enum logic [1:0] {
    DIV  = 2'd0,
    DIVU = 2'd1,
    REM  = 2'd2,
    REMU = 2'd3
  } div_op_e;

  // --------------------------------------------------
  // Operation word and its two views
  // --------------------------------------------------

  typedef struct packed {
    alu_op_e op;
    logic    use_imm;  // Second operand comes from imm instead of rdata2
  } alu_ctrl_t;

  typedef struct packed {
    logic [2:0] rsvd;
    div_op_e    op;
  } div_ctrl_t;

  // The unit field of the operation tells which view holds
  typedef union packed {
    alu_ctrl_t alu;
    div_ctrl_t div;
  } op_word_u;

endpackage

// File: logic/exec_if.sv
`include "exec_settings.svh"

interface exec_if import exec_pkg::*; ();

  logic             enable;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] imm;
  op_word_u         op;
  logic [`XLEN-1:0] result;
  logic             done;

  // Stage side, hands out an operation and collects its result
  modport issue (
    output enable,
    output rdata1,
    output rdata2,
    output imm,
    output op,
    input  result,
    input  done
  );

  // Functional unit side
  modport unit (
    input  enable,
    input  rdata1,
    input  rdata2,
    input  imm,
    input  op,
    output result,
    output done
  );

endinterface

// File: logic/int_alu.sv
`include "exec_settings.svh"

module int_alu import exec_pkg::*; (
  input logic  clk,
  exec_if.unit bus
);

  alu_ctrl_t        ctrl;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic [`XLEN-1:0] res;

  assign ctrl  = bus.op.alu;
  assign op_a  = bus.rdata1;
  assign op_b  = ctrl.use_imm ? bus.imm : bus.rdata2;
  assign shamt = op_b[4:0];  // Only the low bits count for shifts

  // --------------------------------------------------
  // Operation select
  // --------------------------------------------------

  always_comb begin
    case (ctrl.op)
      ADD: begin
        res = op_a + op_b;
      end
      SUB: begin
        res = op_a - op_b;
      end
      AND: begin
        res = op_a & op_b;
      end
      OR: begin
        res = op_a | op_b;
      end
      XOR: begin
        res = op_a ^ op_b;
      end
      SLL: begin
        res = op_a << shamt;
      end
      SRL: begin
        res = op_a >> shamt;
      end
      SRA: begin
        res = $signed(op_a) >>> shamt;
      end
      SLT: begin
        res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      SLTU: begin
        res = {{(`XLEN-1){1'b0}}, op_a < op_b};
      end
      LUI: begin
        res = bus.imm;  // Upper immediate arrives already shifted
      end
      default: begin
        res = '0;
      end
    endcase
  end

  assign bus.result = res;
  assign bus.done   = 1'b1;  // Single cycle, the result is always there

endmodule

// File: logic/seq_divider.sv
`include "exec_settings.svh"

module seq_divider import exec_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  abort,
  exec_if.unit bus
);

  localparam int CW = $clog2(`XLEN);

  logic             busy;
  logic             fin;
  logic [CW-1:0]    count;
  div_op_e          op_q;
  logic             neg_q;
  logic             neg_r;
  logic [`XLEN-1:0] quo;
  logic [`XLEN-1:0] rem;
  logic [`XLEN-1:0] divisor;

  div_ctrl_t        ctrl;
  logic             is_signed;
  logic             a_neg;
  logic             b_neg;
  logic [`XLEN-1:0] abs_a;
  logic [`XLEN-1:0] abs_b;
  logic [`XLEN:0]   partial;
  logic [`XLEN:0]   diff;
  logic [`XLEN-1:0] q_fix;
  logic [`XLEN-1:0] r_fix;

  // --------------------------------------------------
  // Operand preparation
  // --------------------------------------------------

  assign ctrl      = bus.op.div;
  assign is_signed = (ctrl.op == DIV) || (ctrl.op == REM);
  assign a_neg     = is_signed & bus.rdata1[`XLEN-1];
  assign b_neg     = is_signed & bus.rdata2[`XLEN-1];
  assign abs_a     = a_neg ? -bus.rdata1 : bus.rdata1;
  assign abs_b     = b_neg ? -bus.rdata2 : bus.rdata2;

  // One restoring step, remainder shifted left with the next dividend bit
  assign partial = {rem, quo[`XLEN-1]};
  assign diff    = partial - {1'b0, divisor};

  // --------------------------------------------------
  // Control
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy  <= 1'b0;
      fin   <= 1'b0;
      count <= '0;
    end else if (abort) begin
      busy  <= 1'b0;
      fin   <= 1'b0;
      count <= '0;
    end else begin
      fin <= 1'b0;
      if (bus.enable) begin
        busy  <= 1'b1;
        count <= '0;
      end else if (busy) begin
        count <= count + 1'b1;
        if (count == CW'(`XLEN-1)) begin
          busy <= 1'b0;
          fin  <= 1'b1;  // Last step taken
        end
      end
    end
  end

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (bus.enable) begin
      quo     <= abs_a;
      rem     <= '0;
      divisor <= abs_b;
      op_q    <= ctrl.op;
      // A zero divisor must leave the all-ones quotient unsigned
      neg_q   <= (a_neg ^ b_neg) & (|bus.rdata2);
      neg_r   <= a_neg;
    end else if (busy) begin
      if (!diff[`XLEN]) begin
        rem <= diff[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b1};
      end else begin
        rem <= partial[`XLEN-1:0];
        quo <= {quo[`XLEN-2:0], 1'b0};
      end
    end
  end

  assign q_fix = neg_q ? -quo : quo;
  assign r_fix = neg_r ? -rem : rem;

  assign bus.result = ((op_q == REM) || (op_q == REMU)) ? r_fix : q_fix;
  assign bus.done   = fin;

endmodule

// File: logic/exec_writeback.sv
`include "exec_settings.svh"

module exec_writeback import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  unit_e              in_unit,
  input  op_word_u           in_op,
  input  logic [`REG_AW-1:0] in_waddr,
  input  logic [`XLEN-1:0]   in_rdata1,
  input  logic [`XLEN-1:0]   in_rdata2,
  input  logic [`XLEN-1:0]   in_imm,
  input  logic               flush,
  output logic               out_valid,
  input  logic               out_ready,
  output logic [`REG_AW-1:0] out_waddr,
  output logic [`XLEN-1:0]   out_wdata,
  output logic               out_wren,
  output logic               div_abort,
  exec_if.issue              alu,
  exec_if.issue              div
);

  logic               full;
  logic               div_start;
  unit_e              held_unit;
  op_word_u           held_op;
  logic [`REG_AW-1:0] held_waddr;
  logic [`XLEN-1:0]   held_rdata1;
  logic [`XLEN-1:0]   held_rdata2;
  logic [`XLEN-1:0]   held_imm;

  op_word_u           v_op;
  logic [`XLEN-1:0]   v_rdata1;
  logic [`XLEN-1:0]   v_rdata2;
  logic [`XLEN-1:0]   v_imm;
  logic               accept;
  logic               alu_done;
  logic               div_done;
  logic               out_fire;

  assign in_ready  = ~full;  // One operation in flight at most
  assign accept    = in_valid & in_ready;
  assign out_fire  = out_valid & out_ready;
  assign div_abort = flush;

  assign alu_done = accept & (in_unit == UNIT_ALU) & alu.done;
  assign div_done = full & (held_unit == UNIT_DIV) & div.done & ~out_valid;

  // --------------------------------------------------
  // Unit dispatch
  // --------------------------------------------------

  // The incoming operation feeds the units until the stage holds one
  assign v_op     = full ? held_op : in_op;
  assign v_rdata1 = full ? held_rdata1 : in_rdata1;
  assign v_rdata2 = full ? held_rdata2 : in_rdata2;
  assign v_imm    = full ? held_imm : in_imm;

  assign alu.enable = accept & (in_unit == UNIT_ALU);
  assign alu.rdata1 = v_rdata1;
  assign alu.rdata2 = v_rdata2;
  assign alu.imm    = v_imm;
  assign alu.op     = v_op;

  assign div.enable = div_start;  // One cycle after the divide was taken
  assign div.rdata1 = v_rdata1;
  assign div.rdata2 = v_rdata2;
  assign div.imm    = v_imm;
  assign div.op     = v_op;

  // --------------------------------------------------
  // Stage and output control
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst) begin
      full      <= 1'b0;
      div_start <= 1'b0;
      out_valid <= 1'b0;
      out_wren  <= 1'b0;
    end else begin
      div_start <= 1'b0;
      if (flush || out_fire) begin
        full      <= 1'b0;
        out_valid <= 1'b0;
        out_wren  <= 1'b0;
      end else if (div_done) begin
        out_valid <= 1'b1;
        out_wren  <= |held_waddr;  // x0 is never written
      end
      // An empty stage takes a new operation even during a flush
      if (accept) begin
        full <= 1'b1;
        if (in_unit == UNIT_DIV) begin
          div_start <= 1'b1;
        end
      end
      if (alu_done) begin
        out_valid <= 1'b1;
        out_wren  <= |in_waddr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_unit   <= in_unit;
      held_op     <= in_op;
      held_waddr  <= in_waddr;
      held_rdata1 <= in_rdata1;
      held_rdata2 <= in_rdata2;
      held_imm    <= in_imm;
    end
    if (alu_done) begin
      out_waddr <= in_waddr;
      out_wdata <= alu.result;
    end else if (div_done) begin
      out_waddr <= held_waddr;
      out_wdata <= div.result;
    end
  end

endmodule

// File: logic/exec_unit.sv
`include "exec_settings.svh"

module exec_unit import exec_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  unit_e              in_unit,
  input  op_word_u           in_op,
  input  logic [`REG_AW-1:0] in_waddr,
  input  logic [`XLEN-1:0]   in_rdata1,
  input  logic [`XLEN-1:0]   in_rdata2,
  input  logic [`XLEN-1:0]   in_imm,
  input  logic               flush,
  output logic               out_valid,
  input  logic               out_ready,
  output logic [`REG_AW-1:0] out_waddr,
  output logic [`XLEN-1:0]   out_wdata,
  output logic               out_wren
);

  logic div_abort;

  exec_if alu_bus ();
  exec_if div_bus ();

  // --------------------------------------------------
  // Stage register and the two units beside it
  // --------------------------------------------------

  exec_writeback u_writeback (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_unit   (in_unit),
    .in_op     (in_op),
    .in_waddr  (in_waddr),
    .in_rdata1 (in_rdata1),
    .in_rdata2 (in_rdata2),
    .in_imm    (in_imm),
    .flush     (flush),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_waddr (out_waddr),
    .out_wdata (out_wdata),
    .out_wren  (out_wren),
    .div_abort (div_abort),
    .alu       (alu_bus.issue),
    .div       (div_bus.issue)
  );

  int_alu u_alu (
    .clk (clk),
    .bus (alu_bus.unit)
  );

  seq_divider u_divider (
    .clk   (clk),
    .rst   (rst),
    .abort (div_abort),
    .bus   (div_bus.unit)
  );

endmodule

// File: sim/exec_unit_props.sv
`include "exec_settings.svh"

module exec_unit_props (
  input logic               clk,
  input logic               rst,
  input logic               in_ready,
  input logic               flush,
  input logic               out_valid,
  input logic               out_ready,
  input logic [`REG_AW-1:0] out_waddr,
  input logic [`XLEN-1:0]   out_wdata,
  input logic               out_wren
);
  timeunit 1ns;
  timeprecision 1ps;

  logic stalled;

  assign stalled = out_valid & ~out_ready & ~flush;  // A flush may drop the result

  assert property (@(posedge clk) disable iff (!rst) stalled |=> !in_ready)
    else $error("in_ready rose while a result was waiting");

  assert property (@(posedge clk) disable iff (!rst) stalled |=> out_valid)
    else $error("out_valid fell before the write-back transferred");

  // Write-back payload frozen under back-pressure
  assert property (@(posedge clk) disable iff (!rst)
    stalled |=> $stable(out_wdata) && $stable(out_waddr) && $stable(out_wren))
    else $error("write-back data changed while stalled");

  assert property (@(posedge clk) !rst |=> !out_valid)
    else $error("out_valid is set right after reset");

endmodule

bind exec_unit exec_unit_props u_props (
  .clk       (clk),
  .rst       (rst),
  .in_ready  (in_ready),
  .flush     (flush),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_waddr (out_waddr),
  .out_wdata (out_wdata),
  .out_wren  (out_wren)
);

// File: sim/exec_unit_tb.sv
`include "exec_settings.svh"

module exec_unit_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_OPS    = 400;
  localparam int MAX_CYCLES = NUM_OPS * (`XLEN + 10);
  localparam logic [`XLEN-1:0] MIN_INT = {1'b1, {(`XLEN-1){1'b0}}};

  typedef struct packed {
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0]   wdata;
    logic               wren;
  } wb_t;

  logic               clk;
  logic               rst;
  logic               in_valid;
  logic               in_ready;
  unit_e              in_unit;
  op_word_u           in_op;
  logic [`REG_AW-1:0] in_waddr;
  logic [`XLEN-1:0]   in_rdata1;
  logic [`XLEN-1:0]   in_rdata2;
  logic [`XLEN-1:0]   in_imm;
  logic               flush;
  logic               out_valid;
  logic               out_ready;
  logic [`REG_AW-1:0] out_waddr;
  logic [`XLEN-1:0]   out_wdata;
  logic               out_wren;

  wb_t   pending[$];  // Accepted and still owed a write-back
  wb_t   offered;     // Expected result of the operation on the issue port
  unit_e offered_unit;
  int    cycles = 0;

  exec_unit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic logic [`XLEN-1:0] alu_model(alu_ctrl_t c, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] rs2, logic [`XLEN-1:0] imm);
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] r;
    b = c.use_imm ? imm : rs2;
    case (c.op)
      ADD:  r = a + b;
      SUB:  r = a - b;
      AND:  r = a & b;
      OR:   r = a | b;
      XOR:  r = a ^ b;
      SLL:  r = a << b[4:0];
      SRL:  r = a >> b[4:0];
      SRA: begin
        r = a >> b[4:0];
        if (a[`XLEN-1]) r = r | ~({`XLEN{1'b1}} >> b[4:0]);  // Sign fill from the top
      end
      SLT:  r = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
      SLTU: r = (a < b) ? `XLEN'(1) : '0;
      LUI:  r = imm;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [`XLEN-1:0] div_model(div_op_e op, logic [`XLEN-1:0] a,
                                                 logic [`XLEN-1:0] b);
    logic signed [`XLEN-1:0] sa;
    logic signed [`XLEN-1:0] sb;
    logic signed [`XLEN-1:0] sq;
    logic signed [`XLEN-1:0] sr;
    logic                    ovf;
    sa  = a;
    sb  = b;
    ovf = (a == MIN_INT) && (b == '1);
    sq  = '0;
    sr  = '0;
    if (b != '0 && !ovf) begin
      sq = sa / sb;  // Truncates toward zero
      sr = sa % sb;
    end
    // RISC-V results for a zero divisor and for signed overflow
    case (op)
      DIVU:    return (b == '0) ? '1 : a / b;
      REMU:    return (b == '0) ? a : a % b;
      DIV:     return (b == '0) ? '1 : (ovf ? a : sq);
      default: return (b == '0) ? a : (ovf ? '0 : sr);
    endcase
  endfunction

  // --------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------

  function automatic logic [`XLEN-1:0] pick_operand();
    case ($urandom_range(7, 0))
      0:       return '0;
      1:       return '1;
      2:       return MIN_INT;
      3:       return `XLEN'($urandom_range(31, 0));
      default: return `XLEN'($urandom);
    endcase
  endfunction

  task automatic check_value(input string what, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] want);
    if (got !== want) begin
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, want);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic offer_random_op();
    op_word_u           w;
    logic [`REG_AW-1:0] wa;
    logic [`XLEN-1:0]   a;
    logic [`XLEN-1:0]   b;
    logic [`XLEN-1:0]   imm;
    w   = '0;
    a   = pick_operand();
    b   = pick_operand();
    imm = pick_operand();
    wa  = ($urandom_range(7, 0) == 0) ? '0 : `REG_AW'($urandom);
    if ($urandom_range(1, 0) == 1) begin
      offered_unit = UNIT_DIV;
      w.div.op     = div_op_e'(2'($urandom_range(3, 0)));
      case ($urandom_range(7, 0))
        0: b = '0;
        1: begin
          a        = MIN_INT;
          b        = '1;
          w.div.op = ($urandom_range(1, 0) == 1) ? DIV : REM;
        end
        default: begin
        end
      endcase
      offered.wdata = div_model(w.div.op, a, b);
    end else begin
      offered_unit    = UNIT_ALU;
      w.alu.op        = alu_op_e'(4'($urandom_range(10, 0)));
      w.alu.use_imm   = 1'($urandom_range(1, 0));
      if (w.alu.op == LUI) imm[11:0] = '0;
      offered.wdata   = alu_model(w.alu, a, b, imm);
    end
    offered.waddr = wa;
    offered.wren  = (wa != '0);
    in_valid  <= 1'b1;
    in_unit   <= offered_unit;
    in_op     <= w;
    in_waddr  <= wa;
    in_rdata1 <= a;
    in_rdata2 <= b;
    in_imm    <= imm;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: operations still outstanding after %0d cycles", cycles);
      $display("TEST FAIL");
      $fatal(1, "run ended by the cycle limit");
    end
  end

  initial begin
    wb_t got;
    bit  accepted;
    bit  do_flush;
    bit  alu_due;
    int  gap;
    int  issued;
    int  retired;
    int  flushed;
    void'($urandom(64435));
    {alu_due, gap, issued, retired, flushed} = '0;
    rst       = 1'b0;
    in_valid  = 1'b0;
    in_unit   = UNIT_ALU;
    in_op     = '0;
    in_waddr  = '0;
    in_rdata1 = '0;
    in_rdata2 = '0;
    in_imm    = '0;
    flush     = 1'b0;
    out_ready = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    while (retired < NUM_OPS) begin
      @(posedge clk);
      accepted = in_valid && in_ready;
      check_value("in_ready", `XLEN'(in_ready), `XLEN'(pending.size() == 0));
      if (alu_due) check_value("out_valid after an ALU issue", `XLEN'(out_valid), `XLEN'(1));
      alu_due = 1'b0;
      if (flush && pending.size() != 0) begin
        void'(pending.pop_front());  // Dropped by the flush, no write-back owed
        retired++;
        flushed++;
      end else if (out_valid && out_ready) begin
        check_value("pending count at write-back", `XLEN'(pending.size() != 0), `XLEN'(1));
        got = pending.pop_front();
        check_value("out_waddr", `XLEN'(out_waddr), `XLEN'(got.waddr));
        check_value("out_wdata", out_wdata, got.wdata);
        check_value("out_wren", `XLEN'(out_wren), `XLEN'(got.wren));
        retired++;
      end
      if (accepted) begin
        pending.push_back(offered);
        alu_due  = (offered_unit == UNIT_ALU);
        issued++;
        in_valid <= 1'b0;
      end
      // Next cycle inputs
      do_flush  = (pending.size() != 0) && ($urandom_range(127, 0) == 0);
      flush     <= do_flush;
      out_ready <= do_flush ? 1'b0 : ($urandom_range(3, 0) != 0);
      if (!(in_valid && !accepted) && issued < NUM_OPS) begin
        if (gap == 0 || do_flush) begin
          offer_random_op();  // A flush gets a successor right behind it
          gap = $urandom_range(3, 0);
        end else begin
          gap--;
        end
      end
    end
    // Nothing may come out once every operation is accounted for
    repeat (`XLEN + 2) begin
      @(posedge clk);
      check_value("out_valid after the last operation", `XLEN'(out_valid), `XLEN'(0));
      check_value("in_ready after the last operation", `XLEN'(in_ready), `XLEN'(1));
    end
    $display("%0d operations retired, %0d of them flushed", retired, flushed);
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: exec_unit.f
+incdir+include
logic/exec_pkg.sv
logic/exec_if.sv
logic/int_alu.sv
logic/seq_divider.sv
logic/exec_writeback.sv
logic/exec_unit.sv
sim/exec_unit_props.sv
sim/exec_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= exec_unit_tb
FILELIST  ?= exec_unit.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
